// File: common/daq_pkg.sv
package daq_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // widths that carry a meaning
    // ~~~~~~~~~~~~~~~~~~~~

    typedef logic [63:0] sample_t;      // eight ADC bytes, device 0 in the top byte
    typedef logic [7:0]  byte_t;
    typedef logic [5:0]  cache_addr_t;  // block in [5:4], word in [3:0]
    typedef logic [11:0] com_addr_t;
    typedef logic [1:0]  block_idx_t;
    typedef logic [3:0]  ptype_t;
    typedef logic [31:0] stamp_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // geometry and timing
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int DEVICE_NUM    = 8;
    localparam int BLOCK_LEN     = 16;
    localparam int BLOCK_NUM     = 4;
    localparam int CACHE_LATENCY = 2;  // builder address register plus cache read register

    // ~~~~~~~~~~~~~~~~~~~~
    // packet format
    // ~~~~~~~~~~~~~~~~~~~~

    localparam ptype_t PTYPE_STAT = 4'h1;
    localparam ptype_t PTYPE_DATA = 4'h5;

    localparam byte_t STAT_MARK0 = 8'h66;
    localparam byte_t STAT_MARK1 = 8'hBB;
    localparam byte_t DATA_MARK0 = 8'h55;
    localparam byte_t DATA_MARK1 = 8'hAA;

    localparam int STAT_LEN = 14;  // two markers and the 12 byte status word
    localparam int HEAD_LEN = 4;
    localparam int TRIG_LEN = 4;

    localparam com_addr_t COM_STAT_BASE   = 12'h800;
    localparam com_addr_t COM_DATA_BASE   = 12'h000;
    localparam com_addr_t COM_DATA_STRIDE = 12'h100;  // one data packet slot per block

    typedef enum logic [2:0] {
        ST_WAIT,
        ST_STATUS,
        ST_HEAD,
        ST_JUDGE,
        ST_GAP,
        ST_WORK,
        ST_TRIGGER,
        ST_DONE
    } builder_state_t;

endpackage

// File: adc_cache/adc_cache.sv
`timescale 1ns/1ps

module adc_cache (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sample_valid,
    input  daq_pkg::sample_t     sample,
    input  daq_pkg::cache_addr_t rd_addr,
    output daq_pkg::sample_t     rd_data,
    output daq_pkg::stamp_t      blocks_done
);

    localparam int DEPTH = daq_pkg::BLOCK_NUM * daq_pkg::BLOCK_LEN;

    daq_pkg::sample_t     mem [DEPTH];
    daq_pkg::cache_addr_t wr_ptr;

    // ~~~~~~~~~~~~~~~~~~~~
    // write side
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            mem[wr_ptr] <= sample;
        end
    end

    // the pointer wraps from block 3 back to block 0 on its own
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr      <= '0;
            blocks_done <= '0;
        end else if (sample_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
            if (wr_ptr[3:0] == 4'(daq_pkg::BLOCK_LEN - 1)) begin
                blocks_done <= blocks_done + 1'b1;  // last word of a block lands now
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // read side
    // ~~~~~~~~~~~~~~~~~~~~

    // one register stage, data follows the address by a cycle
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: verilog/trigger_stamp.sv
`timescale 1ns/1ps

module trigger_stamp (
    input  logic            clk,
    input  logic            rst,
    input  logic            sample_valid,
    input  logic            trig,
    output daq_pkg::stamp_t trig_stamp,
    output daq_pkg::stamp_t trig_count
);

    daq_pkg::stamp_t sample_count;  // accepted samples since reset

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sample_count <= '0;
            trig_stamp   <= '0;
            trig_count   <= '0;
        end else if (sample_valid) begin
            sample_count <= sample_count + 1'b1;
            if (trig) begin
                // stamp is the index of the triggering sample itself
                trig_stamp <= sample_count;
                trig_count <= trig_count + 1'b1;
            end
        end
    end

endmodule

// File: packet_builder/packet_builder.sv
`timescale 1ns/1ps

module packet_builder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fs,
    output logic                 fd,
    input  daq_pkg::ptype_t      ptype,
    input  daq_pkg::block_idx_t  block_idx,
    input  logic [15:0]          board_id,
    input  logic [15:0]          chan_mode,
    input  daq_pkg::stamp_t      blocks_done,
    input  daq_pkg::stamp_t      trig_stamp,
    input  daq_pkg::stamp_t      trig_count,
    output daq_pkg::cache_addr_t rd_addr,
    input  daq_pkg::sample_t     rd_data,
    output logic                 wr_en,
    output daq_pkg::com_addr_t   wr_addr,
    output daq_pkg::byte_t       wr_data
);

    daq_pkg::builder_state_t state;

    logic [3:0]          byte_cnt;  // byte within the current phase
    logic [3:0]          dev_cnt;   // device under judgement, 8 means all seen
    logic [1:0]          lat_cnt;
    logic                phase_end;
    logic [2:0]          lane;
    daq_pkg::com_addr_t  com_ptr;   // next byte address in the communication RAM
    daq_pkg::byte_t      mask_now;
    daq_pkg::byte_t      dev_mask;
    daq_pkg::byte_t      dev_left;  // mask shifted so bit 7 is always the current device
    daq_pkg::block_idx_t blk;
    logic [95:0]         snap;      // status word or trigger stamp, shifted out from the top

    // a device is on when its 2-bit mode field is nonzero, device 0 maps to bit 7
    always_comb begin
        for (int d = 0; d < daq_pkg::DEVICE_NUM; d++) begin
            mask_now[7 - d] = |chan_mode[15 - 2 * d -: 2];
        end
    end

    assign lane = 3'(daq_pkg::DEVICE_NUM - 1) - dev_cnt[2:0];

    always_comb begin
        case (state)
            daq_pkg::ST_STATUS:  phase_end = (byte_cnt == 4'(daq_pkg::STAT_LEN - 1));
            daq_pkg::ST_HEAD:    phase_end = (byte_cnt == 4'(daq_pkg::HEAD_LEN - 1));
            daq_pkg::ST_WORK:    phase_end = (byte_cnt == 4'(daq_pkg::BLOCK_LEN - 1));
            daq_pkg::ST_TRIGGER: phase_end = (byte_cnt == 4'(daq_pkg::TRIG_LEN - 1));
            default:             phase_end = 1'b0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // sequencing
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= daq_pkg::ST_WAIT;
            byte_cnt <= '0;
            dev_cnt  <= '0;
            lat_cnt  <= '0;
            dev_left <= '0;
            com_ptr  <= '0;
            rd_addr  <= '0;
            wr_addr  <= '0;
            wr_en    <= 1'b0;
            fd       <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            fd    <= 1'b0;
            case (state)
                daq_pkg::ST_WAIT: begin
                    byte_cnt <= '0;
                    dev_cnt  <= '0;
                    // unknown packet types simply keep us here
                    if (fs && ptype == daq_pkg::PTYPE_STAT) begin
                        com_ptr <= daq_pkg::COM_STAT_BASE;
                        state   <= daq_pkg::ST_STATUS;
                    end else if (fs && ptype == daq_pkg::PTYPE_DATA) begin
                        com_ptr  <= daq_pkg::com_addr_t'(daq_pkg::COM_DATA_BASE +
                                    block_idx * daq_pkg::COM_DATA_STRIDE);
                        dev_left <= mask_now;
                        state    <= daq_pkg::ST_HEAD;
                    end
                end
                daq_pkg::ST_STATUS, daq_pkg::ST_HEAD, daq_pkg::ST_WORK,
                daq_pkg::ST_TRIGGER: begin
                    wr_en    <= 1'b1;
                    wr_addr  <= com_ptr;
                    com_ptr  <= com_ptr + 1'b1;
                    byte_cnt <= byte_cnt + 1'b1;
                    if (state == daq_pkg::ST_WORK) begin
                        rd_addr <= rd_addr + 1'b1;
                    end
                    if (phase_end) begin
                        byte_cnt <= '0;
                        case (state)
                            daq_pkg::ST_HEAD: state <= daq_pkg::ST_JUDGE;
                            daq_pkg::ST_WORK: begin
                                dev_cnt  <= dev_cnt + 1'b1;
                                dev_left <= dev_left << 1;
                                state    <= daq_pkg::ST_JUDGE;
                            end
                            default: state <= daq_pkg::ST_DONE;
                        endcase
                    end
                end
                daq_pkg::ST_JUDGE: begin
                    if (dev_cnt == 4'(daq_pkg::DEVICE_NUM)) begin
                        state <= daq_pkg::ST_TRIGGER;
                    end else if (dev_left[7]) begin
                        rd_addr <= daq_pkg::cache_addr_t'({blk, 4'h0});  // word 0 of the block
                        lat_cnt <= 2'd1;  // the judge cycle is the first latency cycle
                        state   <= daq_pkg::ST_GAP;
                    end else begin
                        dev_cnt  <= dev_cnt + 1'b1;  // disabled, move on without reading
                        dev_left <= dev_left << 1;
                    end
                end
                daq_pkg::ST_GAP: begin
                    if (lat_cnt == 2'(daq_pkg::CACHE_LATENCY - 1)) begin
                        rd_addr <= rd_addr + 1'b1;
                        state   <= daq_pkg::ST_WORK;
                    end else begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                end
                daq_pkg::ST_DONE: begin
                    // the last byte is written in the first done cycle, fd rises after it
                    fd <= fs;
                    if (!fs) begin
                        state <= daq_pkg::ST_WAIT;
                    end
                end
                default: state <= daq_pkg::ST_WAIT;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // byte content
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        case (state)
            daq_pkg::ST_WAIT: begin
                if (fs) begin
                    // snapshot taken on the accepting edge keeps a packet self-consistent
                    dev_mask <= mask_now;
                    blk      <= block_idx;
                    if (ptype == daq_pkg::PTYPE_STAT) begin
                        snap <= {board_id, chan_mode, blocks_done, trig_count};
                    end else begin
                        snap <= {trig_stamp, 64'h0};
                    end
                end
            end
            daq_pkg::ST_STATUS: begin
                case (byte_cnt)
                    4'd0: wr_data <= daq_pkg::STAT_MARK0;
                    4'd1: wr_data <= daq_pkg::STAT_MARK1;
                    default: begin
                        wr_data <= snap[95:88];
                        snap    <= snap << 8;
                    end
                endcase
            end
            daq_pkg::ST_HEAD: begin
                case (byte_cnt)
                    4'd0:    wr_data <= daq_pkg::DATA_MARK0;
                    4'd1:    wr_data <= daq_pkg::DATA_MARK1;
                    4'd2:    wr_data <= dev_mask;
                    default: wr_data <= daq_pkg::byte_t'(blk);
                endcase
            end
            daq_pkg::ST_WORK: wr_data <= rd_data[8 * lane +: 8];
            daq_pkg::ST_TRIGGER: begin
                wr_data <= snap[95:88];
                snap    <= snap << 8;
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/com_ram.sv
`timescale 1ns/1ps

module com_ram (
    input  logic               clk,
    input  logic               wr_en,
    input  daq_pkg::com_addr_t wr_addr,
    input  daq_pkg::byte_t     wr_data,
    input  daq_pkg::com_addr_t host_addr,
    output daq_pkg::byte_t     host_data
);

    localparam int DEPTH = 1 << $bits(daq_pkg::com_addr_t);

    daq_pkg::byte_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        host_data <= mem[host_addr];  // host sees data one cycle after the address
    end

endmodule

// File: verilog/daq_packer.sv
`timescale 1ns/1ps

module daq_packer (
    input  logic                clk,
    input  logic                rst,
    input  logic                sample_valid,
    input  daq_pkg::sample_t    sample,
    input  logic                trig,
    input  logic [15:0]         board_id,
    input  logic [15:0]         chan_mode,
    input  logic                fs,
    input  daq_pkg::ptype_t     ptype,
    input  daq_pkg::block_idx_t block_idx,
    output logic                fd,
    input  daq_pkg::com_addr_t  host_addr,
    output daq_pkg::byte_t      host_data
);

    daq_pkg::cache_addr_t rd_addr;
    daq_pkg::sample_t     rd_data;
    daq_pkg::stamp_t      blocks_done;
    daq_pkg::stamp_t      trig_stamp;
    daq_pkg::stamp_t      trig_count;
    logic                 wr_en;
    daq_pkg::com_addr_t   wr_addr;
    daq_pkg::byte_t       wr_data;

    // ~~~~~~~~~~~~~~~~~~~~
    // acquisition side, cache and stamper see the same sample stream
    // ~~~~~~~~~~~~~~~~~~~~

    adc_cache u_cache (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample       (sample),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .blocks_done  (blocks_done)
    );

    trigger_stamp u_stamp (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .trig         (trig),
        .trig_stamp   (trig_stamp),
        .trig_count   (trig_count)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // packet side
    // ~~~~~~~~~~~~~~~~~~~~

    packet_builder u_builder (
        .clk          (clk),
        .rst          (rst),
        .fs           (fs),
        .fd           (fd),
        .ptype        (ptype),
        .block_idx    (block_idx),
        .board_id     (board_id),
        .chan_mode    (chan_mode),
        .blocks_done  (blocks_done),
        .trig_stamp   (trig_stamp),
        .trig_count   (trig_count),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data)
    );

    com_ram u_ram (
        .clk          (clk),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .host_addr    (host_addr),
        .host_data    (host_data)
    );

endmodule

// File: verification/daq_packer_chk.sv
`timescale 1ns/1ps

module daq_packer_chk (
    input logic                    clk,
    input logic                    rst,
    input logic                    fs,
    input logic                    fd,
    input logic                    wr_en,
    input daq_pkg::com_addr_t      wr_addr
);

    // no byte may land once the packet is reported as complete
    quiet_after_done: assert property (@(posedge clk) disable iff (rst) fd |-> !wr_en)
        else $error("write strobe while fd is high");

    fd_follows_fs: assert property (@(posedge clk) disable iff (rst) $fell(fd) |-> !$past(fs))
        else $error("fd fell while fs was still high");

    addr_in_range: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !$isunknown(wr_addr) && (32'(wr_addr) < 32'h1000))
        else $error("write address unknown or outside the RAM");

endmodule

bind packet_builder daq_packer_chk u_chk (
    .clk     (clk),
    .rst     (rst),
    .fs      (fs),
    .fd      (fd),
    .wr_en   (wr_en),
    .wr_addr (wr_addr)
);

// File: verification/daq_packer_tb.sv
`timescale 1ns/1ps

module daq_packer_tb;

    localparam int WAIT_LIMIT = 400;  // cycles allowed for any single wait

    logic                clk = 1'b0;
    logic                rst;
    logic                sample_valid;
    daq_pkg::sample_t    sample;
    logic                trig;
    logic [15:0]         board_id;
    logic [15:0]         chan_mode;
    logic                fs;
    daq_pkg::ptype_t     ptype;
    daq_pkg::block_idx_t block_idx;
    logic                fd;
    daq_pkg::com_addr_t  host_addr;
    daq_pkg::byte_t      host_data;

    // ~~~~~~~~~~~~~~~~~~~~
    // reference model state
    // ~~~~~~~~~~~~~~~~~~~~

    daq_pkg::sample_t ref_cache [daq_pkg::BLOCK_NUM * daq_pkg::BLOCK_LEN];
    int               ref_ptr = 0;
    daq_pkg::stamp_t  ref_samples = '0;
    daq_pkg::stamp_t  ref_stamp = '0;
    daq_pkg::stamp_t  ref_trigs = '0;
    daq_pkg::stamp_t  ref_blocks = '0;
    daq_pkg::byte_t   exp_q [$];
    daq_pkg::byte_t   got_q [$];

    int          seed = 55;
    int          val_errors = 0;
    int          other_errors = 0;
    int          writes;  // write strobes seen during the current request
    logic [31:0] rnd;

    daq_packer DUT (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample       (sample),
        .trig         (trig),
        .board_id     (board_id),
        .chan_mode    (chan_mode),
        .fs           (fs),
        .ptype        (ptype),
        .block_idx    (block_idx),
        .fd           (fd),
        .host_addr    (host_addr),
        .host_data    (host_data)
    );

    always #50 clk = ~clk;

    task automatic check_byte(input string name, input daq_pkg::byte_t exp,
                              input daq_pkg::byte_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            val_errors++;
        end
    endtask

    task automatic check_stamp(input string name, input daq_pkg::stamp_t exp,
                               input daq_pkg::stamp_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            val_errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus and expected packets
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic drive_samples(input int n);
        daq_pkg::sample_t s;
        logic             t;
        for (int i = 0; i < n; i++) begin
            if ($random(seed) % 4 == 0) begin
                @(posedge clk);
                sample_valid <= 1'b0;
                trig         <= 1'b1;  // stray trigger without a sample, must not count
            end
            s = {$random(seed), $random(seed)};
            t = (i % 23 == 11);  // triggers on samples 11, 34 and 57
            @(posedge clk);
            sample_valid <= 1'b1;
            sample       <= s;
            trig         <= t;
            if (t) begin
                ref_stamp = ref_samples;
                ref_trigs++;
            end
            ref_samples++;
            ref_cache[ref_ptr] = s;
            if (ref_ptr % daq_pkg::BLOCK_LEN == daq_pkg::BLOCK_LEN - 1) begin
                ref_blocks++;
            end
            ref_ptr = (ref_ptr + 1) % (daq_pkg::BLOCK_NUM * daq_pkg::BLOCK_LEN);
        end
        @(posedge clk);
        sample_valid <= 1'b0;
        trig         <= 1'b0;
    endtask

    function automatic daq_pkg::com_addr_t packet_base(input daq_pkg::ptype_t pt,
                                                       input daq_pkg::block_idx_t bi);
        if (pt == daq_pkg::PTYPE_STAT) begin
            return daq_pkg::COM_STAT_BASE;
        end
        return daq_pkg::COM_DATA_BASE + daq_pkg::com_addr_t'(bi) * daq_pkg::COM_DATA_STRIDE;
    endfunction

    function automatic void build_expected(input daq_pkg::ptype_t pt,
                                           input daq_pkg::block_idx_t bi);
        logic [95:0]    word;
        daq_pkg::byte_t mask;
        exp_q.delete();
        if (pt == daq_pkg::PTYPE_STAT) begin
            exp_q.push_back(daq_pkg::STAT_MARK0);
            exp_q.push_back(daq_pkg::STAT_MARK1);
            word = {board_id, chan_mode, ref_blocks, ref_trigs};
            for (int i = 11; i >= 0; i--) begin
                exp_q.push_back(word[8 * i +: 8]);
            end
        end else begin
            for (int d = 0; d < daq_pkg::DEVICE_NUM; d++) begin
                mask[7 - d] = (chan_mode[15 - 2 * d -: 2] != 2'b00);
            end
            exp_q.push_back(daq_pkg::DATA_MARK0);
            exp_q.push_back(daq_pkg::DATA_MARK1);
            exp_q.push_back(mask);
            exp_q.push_back(daq_pkg::byte_t'(bi));
            for (int d = 0; d < daq_pkg::DEVICE_NUM; d++) begin
                if (mask[7 - d]) begin
                    for (int w = 0; w < daq_pkg::BLOCK_LEN; w++) begin
                        exp_q.push_back(
                            ref_cache[int'(bi) * daq_pkg::BLOCK_LEN + w][63 - 8 * d -: 8]);
                    end
                end
            end
            for (int i = 3; i >= 0; i--) begin
                exp_q.push_back(ref_stamp[8 * i +: 8]);
            end
        end
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // requests and readback
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic compare_packet(input string name, input daq_pkg::ptype_t pt,
                                  input daq_pkg::block_idx_t bi);
        daq_pkg::com_addr_t base;
        daq_pkg::stamp_t    exp_word;
        daq_pkg::stamp_t    got_word;
        logic               stamp_at;
        int                 i;
        base = packet_base(pt, bi);
        build_expected(pt, bi);
        check_stamp({name, " length"}, exp_q.size(), writes);
        got_q.delete();
        for (int k = 0; k < exp_q.size(); k++) begin
            @(posedge clk);
            host_addr <= base + daq_pkg::com_addr_t'(k);
            @(posedge clk);
            @(negedge clk);
            got_q.push_back(host_data);
        end
        i = 0;
        while (i < exp_q.size()) begin
            // 4-byte counters and stamps are compared as one field
            stamp_at = (pt == daq_pkg::PTYPE_STAT) ? (i == 6 || i == 10) : (i == exp_q.size() - 4);
            if (stamp_at) begin
                exp_word = {exp_q[i], exp_q[i + 1], exp_q[i + 2], exp_q[i + 3]};
                got_word = {got_q[i], got_q[i + 1], got_q[i + 2], got_q[i + 3]};
                check_stamp($sformatf("%s bytes %0d..%0d", name, i, i + 3), exp_word, got_word);
                i += 4;
            end else begin
                check_byte($sformatf("%s byte %0d", name, i), exp_q[i], got_q[i]);
                i++;
            end
        end
    endtask

    task automatic release_request(input string name);
        int n;
        @(posedge clk);
        fs <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (fd && n < WAIT_LIMIT);
        if (fd) begin
            $display("fd stayed high after fs fell in %s", name);
            other_errors++;
        end
    endtask

    task automatic run_request(input string name, input daq_pkg::ptype_t pt,
                               input daq_pkg::block_idx_t bi);
        int n;
        @(posedge clk);
        fs        <= 1'b1;
        ptype     <= pt;
        block_idx <= bi;
        writes = 0;
        n = 0;
        do begin
            @(negedge clk);
            if (DUT.wr_en) begin
                writes++;
            end
            n++;
        end while (!fd && n < WAIT_LIMIT);
        if (!fd) begin
            $display("timeout waiting for fd in %s", name);
            other_errors++;
        end else begin
            compare_packet(name, pt, bi);
        end
        release_request(name);
    endtask

    task automatic run_ignored(input string name, input daq_pkg::ptype_t pt);
        int n;
        @(posedge clk);
        fs    <= 1'b1;
        ptype <= pt;
        writes = 0;
        n = 0;
        do begin
            @(negedge clk);
            if (DUT.wr_en) begin
                writes++;
            end
            n++;
        end while (!fd && n < WAIT_LIMIT);
        if (fd) begin
            $display("fd answered an unknown packet type in %s", name);
            other_errors++;
        end
        check_stamp({name, " writes"}, 0, writes);
        release_request(name);
    endtask

    initial begin
        rst          = 1'b1;
        sample_valid = 1'b0;
        sample       = '0;
        trig         = 1'b0;
        board_id     = 16'hB41F;
        chan_mode    = 16'h9E7D;  // every device field nonzero
        fs           = 1'b0;
        ptype        = '0;
        block_idx    = '0;
        host_addr    = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        drive_samples(70);
        run_request("status", daq_pkg::PTYPE_STAT, 2'd0);
        run_request("data all devices", daq_pkg::PTYPE_DATA, 2'd1);

        // device 2 forced off and device 7 forced on, the rest random
        rnd = $random(seed);
        @(posedge clk);
        chan_mode <= {rnd[15:12], 2'b00, rnd[9:2], 2'b01};
        run_request("data sparse", daq_pkg::PTYPE_DATA, 2'd2);

        @(posedge clk);
        chan_mode <= 16'h3003;
        for (int b = 0; b < daq_pkg::BLOCK_NUM; b++) begin
            run_request($sformatf("data block %0d", b), daq_pkg::PTYPE_DATA,
                        daq_pkg::block_idx_t'(b));
        end

        run_ignored("unknown type", 4'h3);
        run_request("status after unknown", daq_pkg::PTYPE_STAT, 2'd0);

        run_request("first of pair", daq_pkg::PTYPE_DATA, 2'd3);
        run_request("second of pair", daq_pkg::PTYPE_STAT, 2'd0);

        $display("errors: %0d value mismatches, %0d other failures", val_errors, other_errors);
        if (val_errors + other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: daq_packer.f
common/daq_pkg.sv
adc_cache/adc_cache.sv
verilog/trigger_stamp.sv
packet_builder/packet_builder.sv
verilog/com_ram.sv
verilog/daq_packer.sv
verification/daq_packer_chk.sv
verification/daq_packer_tb.sv

// File: Makefile
TOP := daq_packer_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-Mdir obj_dir -f daq_packer.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
